// File: src/spi_macros.svh
`ifndef SPI_MACROS_SVH
`define SPI_MACROS_SVH

// Word and byte widths
`define SPI_WORD_BITS 32
`define SPI_BYTE_BITS 8
`define SPI_LEN_BITS 16
`define SPI_CMD_BITS 2

// Control word field positions
`define SPI_CMD_LSB 24
`define SPI_LEN_LSB 8

// Slave pin synchronizer depth
`define SPI_SYNC_STAGES 3

// Master timing, system cycles per strobe and MOSI hold
`define SPI_DIV_RATIO 4
`define SPI_HOLD_CYCLES 2

`endif

// File: src/spiPkg.sv
`default_nettype none

`include "spi_macros.svh"

package spiPkg;

	// Slave data words and word addresses
	typedef logic [`SPI_WORD_BITS-1:0] spiWordT;

	// Master side transfer byte
	typedef logic [`SPI_BYTE_BITS-1:0] spiByteT;

	// Frame command
	// 0 none, 1 CSR write, 2 CSR read, 3 PSRAM write
	typedef logic [`SPI_CMD_BITS-1:0] spiCmdT;

	// Data length field of the control word
	typedef logic [`SPI_LEN_BITS-1:0] spiLenT;

	// Slave frame phases
	typedef enum logic [1:0]
	{
		addrGet,
		ctrlGet,
		dataGet
	} frameStateT;

endpackage

`default_nettype wire

// File: src/spiFrameIf.sv
`default_nettype none

`include "spi_macros.svh"

interface spiFrameIf;

	// Qualified SCK edge strobes and CS level
	logic sckRise;
	logic sckFall;
	logic csActive;
	// MOSI aligned with the edge strobes
	logic mosiBit;
	// Strobe on the fall that ends a 32-bit word
	logic wordDone;
	// Current frame phase
	spiPkg::frameStateT state;

	modport sync (output sckRise, output sckFall, output csActive, output mosiBit);
	modport count (input sckFall, input csActive, output wordDone);
	modport seq (input csActive, input wordDone, output state);
	modport rx (input sckRise, input sckFall, input csActive, input mosiBit,
		input wordDone, input state);

endinterface

`default_nettype wire

// File: src/spiEdgeSync.sv
`default_nettype none

`include "spi_macros.svh"

module spiEdgeSync (
	input wire iSysClk,
	input wire rstN,
	input wire sck,
	input wire cs,
	input wire mosi,
	spiFrameIf.sync fr
);

	localparam int syncTop = `SPI_SYNC_STAGES - 1;

	logic [syncTop:0] sckSync;
	logic [syncTop:0] csSync;
	logic sckLast;
	// MOSI data path, two stages only
	logic [1:0] mosiDly;

	// ------------------------------
	// Pin synchronizers
	// ------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			sckSync <= '0;
			// CS idles high, no frame after reset
			csSync <= '1;
			sckLast <= 1'b0;
		end
		else
		begin
			sckSync <= {sckSync[syncTop-1:0], sck};
			csSync <= {csSync[syncTop-1:0], cs};
			sckLast <= sckSync[syncTop];
		end
	end

	always_ff @(posedge iSysClk)
	begin
		mosiDly <= {mosiDly[0], mosi};
	end

	// Edges only count inside an active frame
	assign fr.csActive = ~csSync[syncTop];
	assign fr.sckRise = fr.csActive & ~sckLast & sckSync[syncTop];
	assign fr.sckFall = fr.csActive & sckLast & ~sckSync[syncTop];
	assign fr.mosiBit = mosiDly[1];

endmodule

`default_nettype wire

// File: src/spiBitCounter.sv
`default_nettype none

`include "spi_macros.svh"

module spiBitCounter #(
	parameter int countBits = 5
) (
	input wire iSysClk,
	input wire rstN,
	input wire clear,
	input wire step,
	output logic terminal
);

	logic [countBits-1:0] count;
	logic atMax;

	// Last count of the word or byte
	assign atMax = (count == {countBits{1'b1}});

	// ------------------------------
	// Step counter
	// ------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			count <= '0;
		end
		else if (clear)
		begin
			count <= '0;
		end
		else if (step)
		begin
			// Wraps to zero after the terminal step
			count <= count + 1'b1;
		end
	end

	// High only during the step that completes the count
	assign terminal = atMax & step;

endmodule

`default_nettype wire

// File: src/spiFrameSeq.sv
`default_nettype none

`include "spi_macros.svh"

module spiFrameSeq (
	input wire iSysClk,
	input wire rstN,
	spiFrameIf.seq fr
);

	spiPkg::frameStateT stateQ;
	spiPkg::frameStateT stateNext;

	// ------------------------------
	// Next phase
	// ------------------------------
	always_comb
	begin
		stateNext = stateQ;
		if (!fr.csActive)
		begin
			// CS high always restarts the frame
			stateNext = spiPkg::addrGet;
		end
		else if (fr.wordDone)
		begin
			case (stateQ)
				spiPkg::addrGet:
				begin
					stateNext = spiPkg::ctrlGet;
				end
				spiPkg::ctrlGet:
				begin
					stateNext = spiPkg::dataGet;
				end
				// Data words run until CS rises
				default:
				begin
					stateNext = spiPkg::dataGet;
				end
			endcase
		end
	end

	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			stateQ <= spiPkg::addrGet;
		end
		else
		begin
			stateQ <= stateNext;
		end
	end

	assign fr.state = stateQ;

endmodule

`default_nettype wire

// File: src/spiFrameRx.sv
`default_nettype none

`include "spi_macros.svh"

module spiFrameRx (
	input wire iSysClk,
	input wire rstN,
	spiFrameIf.rx fr,
	input spiPkg::spiWordT rdWord,
	output logic miso,
	output spiPkg::spiWordT word,
	output spiPkg::spiWordT addr,
	output spiPkg::spiCmdT cmd,
	output spiPkg::spiLenT len,
	output logic wordValid
);

	spiPkg::spiWordT shiftReg;
	spiPkg::spiWordT misoShift;
	logic inData;

	assign inData = (fr.state == spiPkg::dataGet);

	// ------------------------------
	// MOSI receive
	// ------------------------------
	// MSB first, sampled on rise
	always_ff @(posedge iSysClk)
	begin
		if (fr.sckRise)
		begin
			shiftReg <= {shiftReg[`SPI_WORD_BITS-2:0], fr.mosiBit};
		end
		if (fr.wordDone && inData)
		begin
			word <= shiftReg;
		end
	end

	// Header capture, word strobe and address stepping
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			addr <= '0;
			cmd <= '0;
			len <= '0;
			wordValid <= 1'b0;
		end
		else
		begin
			wordValid <= fr.wordDone & inData;
			if (fr.wordDone && fr.state == spiPkg::addrGet)
			begin
				addr <= shiftReg;
			end
			else if (wordValid)
			begin
				// Next word address, one cycle after the strobe
				addr <= addr + 1'b1;
			end
			if (fr.wordDone && fr.state == spiPkg::ctrlGet)
			begin
				cmd <= shiftReg[`SPI_CMD_LSB +: `SPI_CMD_BITS];
				len <= shiftReg[`SPI_LEN_LSB +: `SPI_LEN_BITS];
			end
		end
	end

	// ------------------------------
	// MISO shifter
	// ------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			misoShift <= '1;
		end
		else if (!fr.csActive || !inData || fr.wordDone)
		begin
			// Fresh read word ahead of the next word's first rise
			misoShift <= rdWord;
		end
		else if (fr.sckFall)
		begin
			misoShift <= {misoShift[`SPI_WORD_BITS-2:0], 1'b1};
		end
	end

	assign miso = misoShift[`SPI_WORD_BITS-1];

endmodule

`default_nettype wire

// File: src/spiByteMaster.sv
`default_nettype none

`include "spi_macros.svh"

module spiByteMaster (
	input wire iSysClk,
	input wire rstN,
	input wire en,
	input spiPkg::spiByteT wrData,
	input wire miso,
	output logic sck,
	output logic mosi,
	output logic cs,
	output spiPkg::spiByteT rdData,
	output logic done
);

	localparam int divBits = $clog2(`SPI_DIV_RATIO);
	localparam int holdBits = $clog2(`SPI_HOLD_CYCLES + 1);

	logic [divBits-1:0] divCnt;
	logic divStrobe;
	logic riseToggle;
	logic fallToggle;
	logic lastFall;
	logic holdBusy;
	logic [holdBits-1:0] holdCnt;
	logic holdDone;
	spiPkg::spiByteT mosiShift;

	assign divStrobe = en & (divCnt == divBits'(`SPI_DIV_RATIO - 1));
	// SCK level before the toggle decides the edge
	assign riseToggle = divStrobe & ~sck;
	assign fallToggle = divStrobe & sck;
	assign holdDone = holdBusy & (holdCnt == holdBits'(`SPI_HOLD_CYCLES - 1));

	// Eighth falling toggle ends the byte
	spiBitCounter #(
		.countBits($clog2(`SPI_BYTE_BITS))
	) uFallCount (
		.iSysClk(iSysClk),
		.rstN(rstN),
		.clear(~en),
		.step(fallToggle),
		.terminal(lastFall)
	);

	// ------------------------------
	// Divider, SCK, hold timer
	// ------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			divCnt <= '0;
			sck <= 1'b0;
			holdBusy <= 1'b0;
			holdCnt <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= lastFall;
			if (!en)
			begin
				divCnt <= '0;
				sck <= 1'b0;
				holdBusy <= 1'b0;
				holdCnt <= '0;
			end
			else
			begin
				divCnt <= divStrobe ? '0 : divCnt + 1'b1;
				if (divStrobe)
				begin
					sck <= ~sck;
				end
				// Hold window starts at each falling toggle
				if (fallToggle)
				begin
					holdBusy <= 1'b1;
					holdCnt <= '0;
				end
				else if (holdDone)
				begin
					holdBusy <= 1'b0;
				end
				else if (holdBusy)
				begin
					holdCnt <= holdCnt + 1'b1;
				end
			end
		end
	end

	// ------------------------------
	// Data shifters
	// ------------------------------
	always_ff @(posedge iSysClk or negedge rstN)
	begin
		if (!rstN)
		begin
			mosiShift <= '1;
		end
		else if (!en)
		begin
			mosiShift <= wrData;
		end
		else if (holdDone)
		begin
			mosiShift <= {mosiShift[`SPI_BYTE_BITS-2:0], 1'b1};
		end
	end

	// MISO sampled on the rising toggle
	always_ff @(posedge iSysClk)
	begin
		if (riseToggle)
		begin
			rdData <= {rdData[`SPI_BYTE_BITS-2:0], miso};
		end
	end

	assign mosi = mosiShift[`SPI_BYTE_BITS-1];
	assign cs = ~en;

endmodule

`default_nettype wire

// File: src/spiBridgeTop.sv
`default_nettype none

`include "spi_macros.svh"

module spiBridgeTop (
	input wire iSysClk,
	input wire rstN,
	// Slave pins
	input wire sSck,
	input wire sCs,
	input wire sMosi,
	output logic sMiso,
	input spiPkg::spiWordT sRdWord,
	// Slave results
	output spiPkg::spiWordT sWord,
	output spiPkg::spiWordT sAddr,
	output spiPkg::spiCmdT sCmd,
	output spiPkg::spiLenT sLen,
	output logic sWordValid,
	// Master side
	input wire mEn,
	input spiPkg::spiByteT mWrData,
	input wire mMiso,
	output logic mSck,
	output logic mMosi,
	output logic mCs,
	output spiPkg::spiByteT mRdData,
	output logic mDone
);

	spiFrameIf fr ();

	// ------------------------------
	// Slave side
	// ------------------------------
	spiEdgeSync uEdgeSync (
		.iSysClk(iSysClk),
		.rstN(rstN),
		.sck(sSck),
		.cs(sCs),
		.mosi(sMosi),
		.fr(fr.sync)
	);

	// Counts falls of one 32-bit word, cleared between frames
	spiBitCounter #(
		.countBits($clog2(`SPI_WORD_BITS))
	) uWordCount (
		.iSysClk(iSysClk),
		.rstN(rstN),
		.clear(~fr.csActive),
		.step(fr.sckFall),
		.terminal(fr.wordDone)
	);

	spiFrameSeq uFrameSeq (
		.iSysClk(iSysClk),
		.rstN(rstN),
		.fr(fr.seq)
	);

	spiFrameRx uFrameRx (
		.iSysClk(iSysClk),
		.rstN(rstN),
		.fr(fr.rx),
		.rdWord(sRdWord),
		.miso(sMiso),
		.word(sWord),
		.addr(sAddr),
		.cmd(sCmd),
		.len(sLen),
		.wordValid(sWordValid)
	);

	// ------------------------------
	// Master side
	// ------------------------------
	spiByteMaster uByteMaster (
		.iSysClk(iSysClk),
		.rstN(rstN),
		.en(mEn),
		.wrData(mWrData),
		.miso(mMiso),
		.sck(mSck),
		.mosi(mMosi),
		.cs(mCs),
		.rdData(mRdData),
		.done(mDone)
	);

endmodule

`default_nettype wire

// File: testbench/spiBridgeTb.sv
`default_nettype none

`include "spi_macros.svh"

module spiBridgeTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numFrames = 4;
	localparam int numBytes = 4;
	// System cycles per sSck level
	localparam int halfBit = 8;
	localparam int cyclesPerBit = 16;
	localparam int marginCycles = 2000;
	localparam int wordBits = `SPI_WORD_BITS;
	localparam int byteBits = `SPI_BYTE_BITS;

	// One slave frame: start address, header fields, full data words,
	// bits of a cut word before CS rises, and the word read back on MISO
	typedef struct packed {
		spiPkg::spiWordT addr;
		spiPkg::spiCmdT cmd;
		spiPkg::spiLenT len;
		logic [7:0] words;
		logic [7:0] abortBits;
		spiPkg::spiWordT rdWord;
	} frameEntryT;

	// One master byte and the reply of the modeled device
	typedef struct packed {
		spiPkg::spiByteT wrData;
		spiPkg::spiByteT reply;
	} byteEntryT;

	logic iSysClk;
	logic rstN;
	logic sSck;
	logic sCs;
	logic sMosi;
	logic sMiso;
	spiPkg::spiWordT sRdWord;
	spiPkg::spiWordT sWord;
	spiPkg::spiWordT sAddr;
	spiPkg::spiCmdT sCmd;
	spiPkg::spiLenT sLen;
	logic sWordValid;
	logic mEn;
	spiPkg::spiByteT mWrData;
	logic mMiso;
	logic mSck;
	logic mMosi;
	logic mCs;
	spiPkg::spiByteT mRdData;
	logic mDone;

	frameEntryT frameTab [numFrames];
	byteEntryT byteTab [numBytes];
	// Words in flight, popped at each sWordValid
	spiPkg::spiWordT expWords [$];
	spiPkg::spiWordT expAddrs [$];
	int errorCount;
	int doneCount;
	int cycleCount;
	int timeoutLimit;

	spiBridgeTop dut_i (
		.iSysClk(iSysClk),
		.rstN(rstN),
		.sSck(sSck),
		.sCs(sCs),
		.sMosi(sMosi),
		.sMiso(sMiso),
		.sRdWord(sRdWord),
		.sWord(sWord),
		.sAddr(sAddr),
		.sCmd(sCmd),
		.sLen(sLen),
		.sWordValid(sWordValid),
		.mEn(mEn),
		.mWrData(mWrData),
		.mMiso(mMiso),
		.mSck(mSck),
		.mMosi(mMosi),
		.mCs(mCs),
		.mRdData(mRdData),
		.mDone(mDone)
	);

	// ------------------------------
	// Clock and watchdog
	// ------------------------------
	initial
	begin
		iSysClk = 1'b0;
		forever
		begin
			#10 iSysClk = ~iSysClk;
		end
	end

	// Limit is set at time zero, before the first edge
	initial
	begin
		cycleCount = 0;
		@(posedge iSysClk);
		while (cycleCount < timeoutLimit)
		begin
			@(posedge iSysClk);
			cycleCount++;
		end
		$display("Timeout: the run did not end within %0d cycles", timeoutLimit);
		$display("SOME TESTS FAILED");
		$finish;
	end

	// ------------------------------
	// Compare tasks
	// ------------------------------
	task automatic checkWord(input string what, input spiPkg::spiWordT got,
		input spiPkg::spiWordT exp);
		if (got !== exp)
		begin
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkCmd(input string what, input spiPkg::spiCmdT got,
		input spiPkg::spiCmdT exp);
		if (got !== exp)
		begin
			$display("Fail %0t: %s is %0d, expected %0d", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkLen(input string what, input spiPkg::spiLenT got,
		input spiPkg::spiLenT exp);
		if (got !== exp)
		begin
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkByte(input string what, input spiPkg::spiByteT got,
		input spiPkg::spiByteT exp);
		if (got !== exp)
		begin
			$display("Fail %0t: %s is %h, expected %h", $time, what, got, exp);
			errorCount++;
		end
	endtask

	task automatic checkBit(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("Fail %0t: %s is %b, expected %b", $time, what, got, exp);
			errorCount++;
		end
	endtask

	// ------------------------------
	// Stimulus tables
	// ------------------------------
	task automatic fillTables();
		// Plain frame, header then three words
		frameTab[0] = '{32'h0000_1000, 2'd1, 16'h0003, 8'd2 + 8'd1, 8'd0, 32'hA5C3_0F96};
		// Cut after 13 bits of a third word
		frameTab[1] = '{32'h2000_00F0, 2'd3, 16'h0010, 8'd2, 8'd13, 32'h1234_5678};
		// Header only, address must still load
		frameTab[2] = '{32'h0BAD_CAFE, 2'd2, 16'h0001, 8'd0, 8'd0, 32'hFFFF_0000};
		// Address wraps through zero
		frameTab[3] = '{32'hFFFF_FFFE, 2'd0, 16'hBEEF, 8'd4, 8'd0, 32'h8000_0001};
		byteTab[0] = '{8'hA5, 8'h3C};
		byteTab[1] = '{8'h00, 8'hFF};
		byteTab[2] = '{8'hFF, 8'h00};
		byteTab[3] = '{8'h96, 8'h69};
	endtask

	// Bits of all entries times the cycles per bit
	function automatic int testCycles();
		int total;
		total = 0;
		for (int f = 0; f < numFrames; f++)
		begin
			total += ((2 + frameTab[f].words) * wordBits + frameTab[f].abortBits) * cyclesPerBit;
		end
		total += numBytes * byteBits * cyclesPerBit;
		return total;
	endfunction

	// ------------------------------
	// SPI master model, slave side
	// ------------------------------
	// One Mode 0 bit, MISO read just before the rising edge
	task automatic sendBit(input logic bitVal, output logic misoBit);
		sMosi = bitVal;
		repeat (halfBit) @(negedge iSysClk);
		misoBit = sMiso;
		sSck = 1'b1;
		repeat (halfBit) @(negedge iSysClk);
		sSck = 1'b0;
	endtask

	task automatic sendWord(input spiPkg::spiWordT data, input int nBits,
		input logic checkMiso, input spiPkg::spiWordT rdWord);
		logic misoBit;
		for (int i = 0; i < nBits; i++)
		begin
			sendBit(data[wordBits - 1 - i], misoBit);
			if (checkMiso)
			begin
				checkBit("sMiso", misoBit, rdWord[wordBits - 1 - i]);
			end
		end
	endtask

	task automatic runFrame(input frameEntryT e);
		spiPkg::spiWordT ctrlWord;
		spiPkg::spiWordT data;
		ctrlWord = '0;
		ctrlWord[`SPI_CMD_LSB +: `SPI_CMD_BITS] = e.cmd;
		ctrlWord[`SPI_LEN_LSB +: `SPI_LEN_BITS] = e.len;
		sRdWord = e.rdWord;
		sCs = 1'b0;
		sendWord(e.addr, wordBits, 1'b0, e.rdWord);
		sendWord(ctrlWord, wordBits, 1'b0, e.rdWord);
		for (int w = 0; w < e.words; w++)
		begin
			data = $urandom;
			// Queued ahead, the pulse lands after the last fall
			expWords.push_back(data);
			expAddrs.push_back(e.addr + spiPkg::spiWordT'(w));
			sendWord(data, wordBits, 1'b1, e.rdWord);
		end
		if (e.abortBits != 0)
		begin
			data = $urandom;
			sendWord(data, e.abortBits, 1'b1, e.rdWord);
		end
		repeat (halfBit) @(negedge iSysClk);
		sCs = 1'b1;
		// Room for the synchronizer and the last pulse
		repeat (4 * halfBit) @(negedge iSysClk);
		checkCmd("sCmd", sCmd, e.cmd);
		checkLen("sLen", sLen, e.len);
		if (e.words == 0)
		begin
			checkWord("sAddr of header only frame", sAddr, e.addr);
		end
		if (expWords.size() != 0)
		begin
			$display("Missing word valid pulses: %0d words never came out", expWords.size());
			errorCount++;
			expWords.delete();
			expAddrs.delete();
		end
	endtask

	// Word strobe monitor
	always @(negedge iSysClk)
	begin
		if (rstN && sWordValid)
		begin
			if (expWords.size() == 0)
			begin
				$display("Unexpected word valid pulse at %0t with no word sent", $time);
				errorCount++;
			end
			else
			begin
				checkWord("sWord", sWord, expWords.pop_front());
				checkWord("sAddr", sAddr, expAddrs.pop_front());
			end
		end
		if (rstN && mDone)
		begin
			doneCount++;
		end
	end

	// ------------------------------
	// SPI device model, master side
	// ------------------------------
	task automatic runByte(input byteEntryT e, input int idx);
		spiPkg::spiByteT sampled;
		logic sckLast;
		int falls;
		sampled = '0;
		sckLast = 1'b0;
		falls = 0;
		mWrData = e.wrData;
		// First reply bit must be there before the first rise
		mMiso = e.reply[byteBits - 1];
		@(negedge iSysClk);
		mEn = 1'b1;
		while (!mDone)
		begin
			@(negedge iSysClk);
			checkBit("mCs", mCs, 1'b0);
			if (mSck && !sckLast)
			begin
				sampled = {sampled[byteBits - 2:0], mMosi};
			end
			else if (!mSck && sckLast)
			begin
				falls++;
				if (falls < byteBits)
				begin
					mMiso = e.reply[byteBits - 1 - falls];
				end
			end
			sckLast = mSck;
		end
		checkByte("mRdData", mRdData, e.reply);
		checkByte("bits seen on mMosi", sampled, e.wrData);
		mEn = 1'b0;
		repeat (halfBit) @(negedge iSysClk);
		if (doneCount != idx + 1)
		begin
			$display("Wrong number of done pulses: %0d after %0d bytes", doneCount, idx + 1);
			errorCount++;
		end
	endtask

	// ------------------------------
	// Main sequence
	// ------------------------------
	initial
	begin
		errorCount = 0;
		doneCount = 0;
		rstN = 1'b0;
		sSck = 1'b0;
		sCs = 1'b1;
		sMosi = 1'b0;
		sRdWord = '0;
		mEn = 1'b0;
		mWrData = '0;
		mMiso = 1'b0;
		void'($urandom(32'hec06e35c));
		fillTables();
		timeoutLimit = marginCycles + testCycles();
		repeat (2) @(posedge iSysClk);
		@(negedge iSysClk);
		rstN = 1'b1;
		// Idle outputs straight after reset
		checkBit("sWordValid after reset", sWordValid, 1'b0);
		checkBit("mDone after reset", mDone, 1'b0);
		checkBit("mSck after reset", mSck, 1'b0);
		repeat (4) @(negedge iSysClk);
		for (int f = 0; f < numFrames; f++)
		begin
			runFrame(frameTab[f]);
		end
		for (int b = 0; b < numBytes; b++)
		begin
			runByte(byteTab[b], b);
		end
		$display("Run complete: %0d errors, %0d frames, %0d bytes, %0d done pulses",
			errorCount, numFrames, numBytes, doneCount);
		if (errorCount == 0)
		begin
			$display("ALL TESTS PASSED");
		end
		else
		begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: flist.f
+incdir+src
src/spiPkg.sv
src/spiFrameIf.sv
src/spiEdgeSync.sv
src/spiBitCounter.sv
src/spiFrameSeq.sv
src/spiFrameRx.sv
src/spiByteMaster.sv
src/spiBridgeTop.sv
testbench/spiBridgeTb.sv

// File: runSim.sh
#!/bin/sh
# Build and run the SPI bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
	--top-module spiBridgeTb -f flist.f -o spiBridgeSim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/spiBridgeSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "SOME TESTS FAILED" "$LOG"; then
	exit 1
fi
if ! grep -q "ALL TESTS PASSED" "$LOG"; then
	echo "No result line found in $LOG"
	exit 1
fi
exit 0
